// ==== src/usb_out_pkg.sv ====
// Package with buffer widths, vector typedefs, register offsets and writer states
package usb_out_pkg;

  // ----------------------------------------
  // Buffer geometry
  // ----------------------------------------

  // Word offset width inside one endpoint bank
  localparam int EP_ADDR_W = 7;

  // Bytes per bank, 128 words of 4 bytes
  localparam int MAX_PKT_BYTES = 512;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------

  // Received byte from the USB side
  typedef logic [7:0] byte_t;

  // Buffer word, lane 0 in bits 7:0
  typedef logic [31:0] word_t;

  // One write enable per byte lane
  typedef logic [3:0] be_t;

  // Packet byte count, 0 up to 512
  typedef logic [9:0] cnt_t;

  // Word offset within a bank
  typedef logic [EP_ADDR_W-1:0] ep_word_t;

  // CPU word address, bit 9 high for register space
  typedef logic [9:0] cpu_addr_t;

  // Register offset in register space
  typedef logic [3:0] reg_off_t;

  // ----------------------------------------
  // Register map
  // ----------------------------------------

  localparam reg_off_t REG_STATUS  = 4'd0;  // full bits, read only
  localparam reg_off_t REG_IRQ_EN  = 4'd1;  // interrupt enable mask
  localparam reg_off_t REG_RELEASE = 4'd2;  // write one to clear full
  localparam reg_off_t REG_COUNT0  = 4'd8;  // count of endpoint e at 8+e

  // ----------------------------------------
  // Writer FSM
  // ----------------------------------------

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_RECV,
    WR_DROP
  } wr_state_t;

endpackage

// ==== src/ep_out_ram.sv ====
// Banked dual-port endpoint buffer RAM with byte-masked write and registered read
module ep_out_ram #(
  parameter int NUM_EP = 4,
  localparam int EP_IDX_W = (NUM_EP > 1) ? $clog2(NUM_EP) : 1,
  localparam int RAM_AW = EP_IDX_W + usb_out_pkg::EP_ADDR_W
) (
  input  logic                clk,
  input  usb_out_pkg::be_t    ram_we,
  input  logic [RAM_AW-1:0]   ram_wr_addr,
  input  usb_out_pkg::word_t  ram_wdata,
  input  logic                ram_rd_en,
  input  logic [RAM_AW-1:0]   ram_rd_addr,
  output usb_out_pkg::word_t  ram_rdata
);
  import usb_out_pkg::*;

  // Read word of every bank, picked by the registered bank number
  word_t               rd_bank [NUM_EP];
  logic [EP_IDX_W-1:0] rd_sel;

  // One 128-word bank per endpoint
  // Upper address bits pick the bank
  for (genvar b = 0; b < NUM_EP; b++) begin : g_bank
    word_t mem [2**EP_ADDR_W];
    word_t rd_q;
    logic  wr_hit;
    logic  rd_hit;

    assign wr_hit = (ram_wr_addr[RAM_AW-1:EP_ADDR_W] == EP_IDX_W'(b));
    assign rd_hit = (ram_rd_addr[RAM_AW-1:EP_ADDR_W] == EP_IDX_W'(b));

    always_ff @(posedge clk) begin
      // Lanes without enable keep old bytes
      for (int l = 0; l < 4; l++) begin
        if (ram_we[l] && wr_hit)
          mem[ram_wr_addr[EP_ADDR_W-1:0]][8*l +: 8] <= ram_wdata[8*l +: 8];
      end
      // Output holds while not enabled
      if (ram_rd_en && rd_hit)
        rd_q <= mem[ram_rd_addr[EP_ADDR_W-1:0]];
    end

    assign rd_bank[b] = rd_q;
  end

  // Bank number travels with the read
  always_ff @(posedge clk) begin
    if (ram_rd_en)
      rd_sel <= ram_rd_addr[RAM_AW-1:EP_ADDR_W];
  end

  assign ram_rdata = rd_bank[rd_sel];

  // Accesses stay inside the populated banks
  a_bank_range : assert property (@(posedge clk)
    ((|ram_we) |-> (ram_wr_addr[RAM_AW-1:EP_ADDR_W] < NUM_EP)) and
    (ram_rd_en |-> (ram_rd_addr[RAM_AW-1:EP_ADDR_W] < NUM_EP)));

endmodule

// ==== src/ep_out_writer.sv ====
// Packet writer: byte packing, masked bank writes, commit, NAK and drop FSM
module ep_out_writer #(
  parameter int NUM_EP = 4,
  localparam int EP_IDX_W = (NUM_EP > 1) ? $clog2(NUM_EP) : 1,
  localparam int RAM_AW = EP_IDX_W + usb_out_pkg::EP_ADDR_W
) (
  input  logic                clk,
  input  logic                rst_n,
  // USB receive side
  input  logic                rx_start,
  input  logic [EP_IDX_W-1:0] rx_ep,
  input  logic                rx_valid,
  input  usb_out_pkg::byte_t  rx_data,
  input  logic                rx_last,
  input  logic                rx_abort,
  // Full flags from the register block
  input  logic [NUM_EP-1:0]   ep_full,
  // RAM write port
  output usb_out_pkg::be_t    ram_we,
  output logic [RAM_AW-1:0]   ram_wr_addr,
  output usb_out_pkg::word_t  ram_wdata,
  // Commit towards the register block
  output logic                commit,
  output logic [EP_IDX_W-1:0] commit_ep,
  output usb_out_pkg::cnt_t   commit_count,
  // Handshake pulses
  output logic                usb_ack,
  output logic                usb_nak
);
  import usb_out_pkg::*;

  wr_state_t           state;
  logic [EP_IDX_W-1:0] cur_ep;
  cnt_t                byte_cnt;
  word_t               asm_word;
  be_t                 asm_mask;
  logic [1:0]          lane;
  word_t               next_word;
  be_t                 next_mask;
  logic                tgt_full;
  logic                overflow;

  // ----------------------------------------
  // Byte placement
  // ----------------------------------------

  // Byte n lands in lane n mod 4
  assign lane = byte_cnt[1:0];

  always_comb begin
    next_word = asm_word;
    next_word[8*lane +: 8] = rx_data;
    next_mask = asm_mask;
    next_mask[lane] = 1'b1;
  end

  // Full now, or being committed this cycle
  assign tgt_full = ep_full[rx_ep] | (commit & (commit_ep == rx_ep));

  // Bank already holds 512 bytes
  assign overflow = (byte_cnt == cnt_t'(MAX_PKT_BYTES));

  // ----------------------------------------
  // Control FSM
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= WR_IDLE;
      byte_cnt <= '0;
      asm_mask <= '0;
      ram_we   <= '0;
      commit   <= 1'b0;
      usb_ack  <= 1'b0;
      usb_nak  <= 1'b0;
    end else begin
      // Strobes last one cycle
      ram_we  <= '0;
      commit  <= 1'b0;
      usb_ack <= 1'b0;
      usb_nak <= 1'b0;
      case (state)
        WR_IDLE: begin
          if (rx_start) begin
            byte_cnt <= '0;
            asm_mask <= '0;
            if (tgt_full) begin
              state   <= WR_DROP;
              usb_nak <= 1'b1;
            end else begin
              state <= WR_RECV;
            end
          end
        end
        WR_RECV: begin
          if (rx_abort) begin
            state <= WR_IDLE;
          end else if (rx_valid) begin
            if (overflow) begin
              // Byte 513, rest of packet is thrown away
              state <= rx_last ? WR_IDLE : WR_DROP;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
              // Flush on a full word or the final byte
              if (lane == 2'd3 || rx_last) begin
                ram_we   <= next_mask;
                asm_mask <= '0;
              end else begin
                asm_mask <= next_mask;
              end
              if (rx_last) begin
                state   <= WR_IDLE;
                commit  <= 1'b1;
                usb_ack <= 1'b1;
              end
            end
          end
        end
        WR_DROP: begin
          // Wait for the end of the refused packet
          if (rx_abort || (rx_valid && rx_last))
            state <= WR_IDLE;
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // Data path
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (state == WR_IDLE && rx_start)
      cur_ep <= rx_ep;
    if (state == WR_RECV && rx_valid) begin
      asm_word     <= next_word;
      ram_wdata    <= next_word;
      ram_wr_addr  <= {cur_ep, ep_word_t'(byte_cnt[EP_ADDR_W+1:2])};
      commit_ep    <= cur_ep;
      commit_count <= byte_cnt + 1'b1;
    end
  end

  // Accepted packets only target empty buffers
  a_commit_empty : assert property (@(posedge clk) disable iff (!rst_n)
    commit |-> !ep_full[commit_ep]);

  a_ack_nak : assert property (@(posedge clk) disable iff (!rst_n)
    !(usb_ack && usb_nak));

  // Bytes only after rx_start
  a_no_idle_byte : assert property (@(posedge clk) disable iff (!rst_n)
    (state == WR_IDLE) |-> !rx_valid);

endmodule

// ==== src/ep_out_regs.sv ====
// Register block: full flags, byte counts, interrupt enable, release and read mux
module ep_out_regs #(
  parameter int NUM_EP = 4,
  localparam int EP_IDX_W = (NUM_EP > 1) ? $clog2(NUM_EP) : 1
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // Commit from the writer
  input  logic                  commit,
  input  logic [EP_IDX_W-1:0]   commit_ep,
  input  usb_out_pkg::cnt_t     commit_count,
  // Register access from the CPU interface
  input  logic                  reg_wr,
  input  usb_out_pkg::reg_off_t reg_addr,
  input  usb_out_pkg::word_t    reg_wdata,
  output usb_out_pkg::word_t    reg_rdata,
  // Status outputs
  output logic [NUM_EP-1:0]     ep_full,
  output logic                  irq
);
  import usb_out_pkg::*;

  logic [NUM_EP-1:0] irq_en;
  cnt_t              count [NUM_EP];
  logic [NUM_EP-1:0] set_mask;
  logic [NUM_EP-1:0] rel_mask;

  // ----------------------------------------
  // Flag updates
  // ----------------------------------------

  // One-hot of the committing endpoint
  always_comb begin
    for (int e = 0; e < NUM_EP; e++)
      set_mask[e] = commit && (commit_ep == EP_IDX_W'(e));
  end

  // Ones written to RELEASE clear flags
  assign rel_mask = (reg_wr && reg_addr == REG_RELEASE) ? reg_wdata[NUM_EP-1:0] : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ep_full <= '0;
      irq_en  <= '0;
      irq     <= 1'b0;
      for (int e = 0; e < NUM_EP; e++)
        count[e] <= '0;
    end else begin
      // Commit wins over a release in the same cycle
      ep_full <= (ep_full & ~rel_mask) | set_mask;
      // Count kept after release, CPU may still read it
      if (commit)
        count[commit_ep] <= commit_count;
      if (reg_wr && reg_addr == REG_IRQ_EN)
        irq_en <= reg_wdata[NUM_EP-1:0];
      // Level interrupt, any enabled full buffer
      irq <= |(ep_full & irq_en);
    end
  end

  // ----------------------------------------
  // Read mux
  // ----------------------------------------

  always_comb begin
    reg_rdata = '0;
    case (reg_addr)
      REG_STATUS: reg_rdata[NUM_EP-1:0] = ep_full;
      REG_IRQ_EN: reg_rdata[NUM_EP-1:0] = irq_en;
      default: begin
        // Count registers from offset 8 upward
        for (int e = 0; e < NUM_EP; e++) begin
          if (reg_addr == reg_off_t'(REG_COUNT0 + e))
            reg_rdata = word_t'(count[e]);
        end
      end
    endcase
  end

  // Writer never reports more than one bank
  a_count_range : assert property (@(posedge clk) disable iff (!rst_n)
    commit |-> (commit_count <= cnt_t'(MAX_PKT_BYTES)));

endmodule

// ==== src/ep_out_cpu_if.sv ====
// CPU port: address split, register writes and one-cycle read return
module ep_out_cpu_if #(
  parameter int NUM_EP = 4,
  localparam int EP_IDX_W = (NUM_EP > 1) ? $clog2(NUM_EP) : 1,
  localparam int RAM_AW = EP_IDX_W + usb_out_pkg::EP_ADDR_W
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // CPU bus
  input  usb_out_pkg::cpu_addr_t cpu_addr,
  input  logic                   cpu_rd,
  input  logic                   cpu_wr,
  input  usb_out_pkg::word_t     cpu_wdata,
  output usb_out_pkg::word_t     cpu_rdata,
  output logic                   cpu_rvalid,
  // Buffer read port
  output logic                   ram_rd_en,
  output logic [RAM_AW-1:0]      ram_rd_addr,
  input  usb_out_pkg::word_t     ram_rdata,
  // Register block
  output logic                   reg_wr,
  output usb_out_pkg::reg_off_t  reg_addr,
  output usb_out_pkg::word_t     reg_wdata,
  input  usb_out_pkg::word_t     reg_rdata
);
  import usb_out_pkg::*;

  // Top address bit picks register space
  localparam int REG_SEL_BIT = $bits(cpu_addr_t) - 1;

  logic  reg_space;
  logic  rd_is_reg;
  word_t reg_cap;

  assign reg_space = cpu_addr[REG_SEL_BIT];

  // Buffer space, endpoint above the word offset
  assign ram_rd_en   = cpu_rd & ~reg_space;
  assign ram_rd_addr = cpu_addr[RAM_AW-1:0];

  // Buffer space writes go nowhere
  assign reg_wr    = cpu_wr & reg_space;
  assign reg_addr  = reg_off_t'(cpu_addr);
  assign reg_wdata = cpu_wdata;

  always_ff @(posedge clk) begin
    if (!rst_n)
      cpu_rvalid <= 1'b0;
    else
      cpu_rvalid <= cpu_rd;
  end

  // Register value and space of the pending read
  always_ff @(posedge clk) begin
    if (cpu_rd) begin
      rd_is_reg <= reg_space;
      if (reg_space)
        reg_cap <= reg_rdata;
    end
  end

  // RAM output already registered, both paths line up
  assign cpu_rdata = rd_is_reg ? reg_cap : ram_rdata;

  a_rd_wr_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(cpu_rd && cpu_wr));

endmodule

// ==== src/usb_out_buf.sv ====
// Top level of the OUT endpoint receive buffer, instances and wiring
module usb_out_buf #(
  parameter int NUM_EP = 4,
  localparam int EP_IDX_W = (NUM_EP > 1) ? $clog2(NUM_EP) : 1
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // USB receive side
  input  logic                   rx_start,
  input  logic [EP_IDX_W-1:0]    rx_ep,
  input  logic                   rx_valid,
  input  usb_out_pkg::byte_t     rx_data,
  input  logic                   rx_last,
  input  logic                   rx_abort,
  output logic                   usb_ack,
  output logic                   usb_nak,
  // CPU side
  input  usb_out_pkg::cpu_addr_t cpu_addr,
  input  logic                   cpu_rd,
  input  logic                   cpu_wr,
  input  usb_out_pkg::word_t     cpu_wdata,
  output usb_out_pkg::word_t     cpu_rdata,
  output logic                   cpu_rvalid,
  output logic                   irq
);
  import usb_out_pkg::*;

  localparam int RAM_AW = EP_IDX_W + EP_ADDR_W;

  // ----------------------------------------
  // Internal nets
  // ----------------------------------------

  // Writer to RAM
  be_t                 ram_we;
  logic [RAM_AW-1:0]   ram_wr_addr;
  word_t               ram_wdata;

  // CPU port to RAM
  logic                ram_rd_en;
  logic [RAM_AW-1:0]   ram_rd_addr;
  word_t               ram_rdata;

  // Writer and register block
  logic                commit;
  logic [EP_IDX_W-1:0] commit_ep;
  cnt_t                commit_count;
  logic [NUM_EP-1:0]   ep_full;

  // CPU port to register block
  logic                reg_wr;
  reg_off_t            reg_addr;
  word_t               reg_wdata;
  word_t               reg_rdata;

  // ----------------------------------------
  // Instances
  // ----------------------------------------

  ep_out_writer #(.NUM_EP(NUM_EP)) u_writer (
    .clk, .rst_n,
    .rx_start, .rx_ep, .rx_valid, .rx_data, .rx_last, .rx_abort,
    .ep_full,
    .ram_we, .ram_wr_addr, .ram_wdata,
    .commit, .commit_ep, .commit_count,
    .usb_ack, .usb_nak
  );

  ep_out_ram #(.NUM_EP(NUM_EP)) u_ram (
    .clk,
    .ram_we, .ram_wr_addr, .ram_wdata,
    .ram_rd_en, .ram_rd_addr, .ram_rdata
  );

  ep_out_regs #(.NUM_EP(NUM_EP)) u_regs (
    .clk, .rst_n,
    .commit, .commit_ep, .commit_count,
    .reg_wr, .reg_addr, .reg_wdata, .reg_rdata,
    .ep_full, .irq
  );

  ep_out_cpu_if #(.NUM_EP(NUM_EP)) u_cpu_if (
    .clk, .rst_n,
    .cpu_addr, .cpu_rd, .cpu_wr, .cpu_wdata, .cpu_rdata, .cpu_rvalid,
    .ram_rd_en, .ram_rd_addr, .ram_rdata,
    .reg_wr, .reg_addr, .reg_wdata, .reg_rdata
  );

endmodule

// ==== verif/usb_out_buf_tb.sv ====
// OUT endpoint buffer testbench with clock, reset, LCG, reference model and directed tests
module usb_out_buf_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import usb_out_pkg::*;

  localparam int NUM_EP = 4;
  // Twenty random packets of up to 518 cycles and 130 two-cycle reads each
  // come to about 15700 cycles
  // Directed tests add about 2600
  localparam int TIMEOUT_CYCLES = 20000;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       rx_start;
  logic [1:0] rx_ep;
  logic       rx_valid;
  byte_t      rx_data;
  logic       rx_last;
  logic       rx_abort;
  logic       usb_ack;
  logic       usb_nak;
  cpu_addr_t  cpu_addr;
  logic       cpu_rd;
  logic       cpu_wr;
  word_t      cpu_wdata;
  word_t      cpu_rdata;
  logic       cpu_rvalid;
  logic       irq;

  // Reference model with bank bytes, known flags, counts and full flags
  byte_t             model_byte [NUM_EP][MAX_PKT_BYTES];
  logic              model_known [NUM_EP][MAX_PKT_BYTES];
  int                exp_count [NUM_EP];
  logic [NUM_EP-1:0] exp_full;

  byte_t       pkt [1024];
  logic [31:0] lcg_state = 32'hae67_21c0;
  int          ack_seen = 0;
  int          nak_seen = 0;
  int          ack_cycle = 0;
  int          nak_cycle = 0;
  int          cycle_cnt = 0;
  int          ack_pulses;
  int          nak_pulses;
  int          exp_ack_cycle;
  int          exp_nak_cycle;

  always #2 clk = ~clk;

  usb_out_buf #(.NUM_EP(NUM_EP)) DUT (
    .clk, .rst_n,
    .rx_start, .rx_ep, .rx_valid, .rx_data, .rx_last, .rx_abort,
    .usb_ack, .usb_nak,
    .cpu_addr, .cpu_rd, .cpu_wr, .cpu_wdata, .cpu_rdata, .cpu_rvalid, .irq
  );

  // Handshake pulses counted and stamped away from the active edge
  always @(negedge clk) begin
    if (usb_ack) begin
      ack_seen++;
      ack_cycle = cycle_cnt;
    end
    if (usb_nak) begin
      nak_seen++;
      nak_cycle = cycle_cnt;
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES)
      stop_fail("Timeout: the tests did not finish within the cycle limit");
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected)
      stop_fail($sformatf("ERROR at %0t ns: %s got 0x%08h, expected 0x%08h",
                          $time, name, got, expected));
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Register space has bit 9 set
  function automatic cpu_addr_t reg_cpu_addr(input reg_off_t off);
    return {1'b1, 5'b0, off};
  endfunction

  // Buffer space with the endpoint above the word offset
  function automatic cpu_addr_t buf_cpu_addr(input int ep, input int w);
    return {1'b0, ep[1:0], w[6:0]};
  endfunction

  task automatic cpu_write(input cpu_addr_t addr, input word_t data);
    @(posedge clk);
    cpu_wr    <= 1'b1;
    cpu_addr  <= addr;
    cpu_wdata <= data;
    @(posedge clk);
    cpu_wr <= 1'b0;
  endtask

  // Data one cycle after the strobe
  task automatic cpu_read(input cpu_addr_t addr, output word_t data);
    @(posedge clk);
    cpu_rd   <= 1'b1;
    cpu_addr <= addr;
    @(posedge clk);
    cpu_rd <= 1'b0;
    @(negedge clk);
    check("cpu_rvalid", 32'(cpu_rvalid), 32'd1);
    data = cpu_rdata;
  endtask

  // ----------------------------------------
  // Packet driver and model
  // ----------------------------------------

  // Bytes from the LCG for data_src 0 and from a counting pattern otherwise
  // abort_at >= 0 pulses rx_abort after that many bytes
  task automatic send_packet(input int ep, input int len, input int data_src, input int abort_at);
    int ack0;
    int nak0;
    int nbytes;
    ack0   = ack_seen;
    nak0   = nak_seen;
    nbytes = (abort_at >= 0) ? abort_at : len;
    for (int n = 0; n < len; n++)
      pkt[n] = (data_src == 0) ? byte_t'(next_random() >> 16) : byte_t'(n + data_src * 37);
    @(posedge clk);
    rx_start <= 1'b1;
    rx_ep    <= ep[1:0];
    // Counter still holds its value from before this edge
    // NAK in the cycle after the rx_start edge
    exp_nak_cycle = cycle_cnt + 2;
    // ACK in the cycle after the last byte edge
    exp_ack_cycle = cycle_cnt + 2 + len;
    @(posedge clk);
    rx_start <= 1'b0;
    for (int n = 0; n < nbytes; n++) begin
      rx_valid <= 1'b1;
      rx_data  <= pkt[n];
      rx_last  <= (n == len - 1);
      @(posedge clk);
    end
    rx_valid <= 1'b0;
    rx_last  <= 1'b0;
    if (abort_at >= 0) begin
      rx_abort <= 1'b1;
      @(posedge clk);
      rx_abort <= 1'b0;
    end
    // Room for the ACK one cycle after the last byte
    repeat (3) @(negedge clk);
    ack_pulses = ack_seen - ack0;
    nak_pulses = nak_seen - nak0;
  endtask

  task automatic expect_handshake(input logic ack, input logic nak);
    if (ack && ack_pulses == 0)
      stop_fail("Accepted packet was not answered with usb_ack");
    check("usb_ack pulses", ack_pulses, 32'(ack));
    check("usb_nak pulses", nak_pulses, 32'(nak));
    if (ack)
      check("usb_ack cycle", exp_ack_cycle == ack_cycle ? ack_cycle : ack_cycle, exp_ack_cycle);
    if (nak)
      check("usb_nak cycle", nak_cycle, exp_nak_cycle);
  endtask

  task automatic commit_model(input int ep, input int len);
    for (int n = 0; n < len; n++) begin
      model_byte[ep][n]  = pkt[n];
      model_known[ep][n] = 1'b1;
    end
    exp_count[ep] = len;
    exp_full[ep]  = 1'b1;
  endtask

  // Dropped packets may leave partial words behind
  task automatic drop_model(input int ep, input int len);
    for (int n = 0; n < len && n < MAX_PKT_BYTES; n++)
      model_known[ep][n] = 1'b0;
  endtask

  task automatic release_ep(input int ep);
    cpu_write(reg_cpu_addr(REG_RELEASE), word_t'(1) << ep);
    exp_full[ep] = 1'b0;
  endtask

  // Reads status and count and every word touched by len bytes
  task automatic verify_endpoint(input int ep, input int len);
    word_t got;
    word_t exp_w;
    word_t mask;
    cpu_read(reg_cpu_addr(REG_STATUS), got);
    check("status", got, word_t'(exp_full));
    cpu_read(reg_cpu_addr(reg_off_t'(REG_COUNT0 + ep)), got);
    check($sformatf("count%0d", ep), got, word_t'(exp_count[ep]));
    for (int w = 0; w < (len + 3) / 4; w++) begin
      cpu_read(buf_cpu_addr(ep, w), got);
      exp_w = '0;
      mask  = '0;
      for (int l = 0; l < 4; l++) begin
        if (model_known[ep][4*w+l]) begin
          exp_w[8*l +: 8] = model_byte[ep][4*w+l];
          mask[8*l +: 8]  = 8'hff;
        end
      end
      check($sformatf("cpu_rdata ep%0d word%0d", ep, w), got & mask, exp_w);
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------

  task automatic test_reset();
    word_t got;
    check("irq", 32'(irq), 32'd0);
    cpu_read(reg_cpu_addr(REG_STATUS), got);
    check("status", got, 32'd0);
    cpu_read(reg_cpu_addr(REG_IRQ_EN), got);
    check("irq_en", got, 32'd0);
    for (int e = 0; e < NUM_EP; e++) begin
      cpu_read(reg_cpu_addr(reg_off_t'(REG_COUNT0 + e)), got);
      check($sformatf("count%0d", e), got, 32'd0);
    end
  endtask

  task automatic test_aligned();
    word_t got;
    send_packet(1, 64, 1, -1);
    expect_handshake(1'b1, 1'b0);
    commit_model(1, 64);
    verify_endpoint(1, 64);
    // Full but still masked
    check("irq", 32'(irq), 32'd0);
    cpu_write(reg_cpu_addr(REG_IRQ_EN), 32'h2);
    cpu_read(reg_cpu_addr(REG_STATUS), got);
    check("irq", 32'(irq), 32'd1);
    release_ep(1);
    cpu_read(reg_cpu_addr(REG_STATUS), got);
    check("status", got, 32'd0);
    check("irq", 32'(irq), 32'd0);
    cpu_write(reg_cpu_addr(REG_IRQ_EN), 32'h0);
  endtask

  // Shorter packets over a longer one keep the old lanes
  task automatic test_unaligned();
    int lens [3] = '{511, 5, 1};
    for (int i = 0; i < 3; i++) begin
      send_packet(2, lens[i], 2 + i, -1);
      expect_handshake(1'b1, 1'b0);
      commit_model(2, lens[i]);
      verify_endpoint(2, lens[i]);
      release_ep(2);
    end
  endtask

  task automatic test_full_nak();
    send_packet(3, 20, 5, -1);
    expect_handshake(1'b1, 1'b0);
    commit_model(3, 20);
    // Second packet refused while the buffer is full
    send_packet(3, 20, 9, -1);
    expect_handshake(1'b0, 1'b1);
    verify_endpoint(3, 20);
    release_ep(3);
    send_packet(3, 20, 9, -1);
    expect_handshake(1'b1, 1'b0);
    commit_model(3, 20);
    verify_endpoint(3, 20);
    release_ep(3);
  endtask

  task automatic test_drop();
    send_packet(2, 40, 3, 17);
    expect_handshake(1'b0, 1'b0);
    drop_model(2, 17);
    verify_endpoint(2, 0);
    // Oversize packet dropped at byte 513
    send_packet(2, 600, 4, -1);
    expect_handshake(1'b0, 1'b0);
    drop_model(2, 600);
    verify_endpoint(2, 0);
    send_packet(2, 33, 6, -1);
    expect_handshake(1'b1, 1'b0);
    commit_model(2, 33);
    verify_endpoint(2, 33);
    release_ep(2);
  endtask

  task automatic test_random();
    int ep;
    int len;
    cpu_write(reg_cpu_addr(REG_RELEASE), 32'hf);
    exp_full = '0;
    repeat (20) begin
      ep  = int'(next_random() >> 8) % NUM_EP;
      len = int'(next_random() >> 8) % MAX_PKT_BYTES + 1;
      send_packet(ep, len, 0, -1);
      expect_handshake(1'b1, 1'b0);
      commit_model(ep, len);
      verify_endpoint(ep, len);
      release_ep(ep);
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    rx_start  = 1'b0;
    rx_ep     = '0;
    rx_valid  = 1'b0;
    rx_data   = '0;
    rx_last   = 1'b0;
    rx_abort  = 1'b0;
    cpu_addr  = '0;
    cpu_rd    = 1'b0;
    cpu_wr    = 1'b0;
    cpu_wdata = '0;
    exp_full  = '0;
    for (int e = 0; e < NUM_EP; e++) begin
      exp_count[e] = 0;
      for (int n = 0; n < MAX_PKT_BYTES; n++)
        model_known[e][n] = 1'b0;
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    test_reset();
    test_aligned();
    test_unaligned();
    test_full_nak();
    test_drop();
    test_random();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== usb_out_buf.f ====
src/usb_out_pkg.sv
src/ep_out_ram.sv
src/ep_out_writer.sv
src/ep_out_regs.sv
src/ep_out_cpu_if.sv
src/usb_out_buf.sv
verif/usb_out_buf_tb.sv

// ==== Makefile ====
# Verilator build and run of the OUT endpoint buffer testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	rm -f $(LOG)
	verilator --binary --timing -j 0 --top-module usb_out_buf_tb \
		-f usb_out_buf.f --Mdir obj_dir -o usb_out_buf_sim
	-./obj_dir/usb_out_buf_sim | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
